// ==== logic/imul_cfg.svh ====
//--------------------------------------
// imul config: operand width, request
// queue depth and iteration count
//--------------------------------------

`ifndef IMUL_CFG_SVH
`define IMUL_CFG_SVH

// operand width in bits
`define IMUL_WIDTH 32

// queued requests ahead of the multiplier
`define IMUL_FIFO_DEPTH 4

// one shift-and-add per operand bit
`define IMUL_STEPS `IMUL_WIDTH

`endif

// ==== logic/imul_pkg.sv ====
//--------------------------------------
// imul package: operand, product and
// controller state types
//--------------------------------------

`include "imul_cfg.svh"

package imul_pkg;

  // signed operand word
  typedef logic signed [`IMUL_WIDTH-1:0] operand_t;

  // full signed product, twice the operand width
  typedef logic signed [2*`IMUL_WIDTH-1:0] product_t;

  // iterative multiply controller states
  //   IDLE  waiting for a queued request
  //   CALC  one shift-and-add per cycle
  //   DONE  product held until accepted
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } ctrl_state_t;

endpackage

// ==== logic/imul_req_if.sv ====
//--------------------------------------
// imul request link: queued operand
// pair from the FIFO to the multiplier
//--------------------------------------

interface imul_req_if;
  import imul_pkg::*;

  // head-of-queue operands
  operand_t a;
  operand_t b;

  // val/rdy handshake
  logic val;
  logic rdy;

  // queue side drives the request
  modport fifo_side (
    output a,
    output b,
    output val,
    input  rdy
  );

  // multiplier side takes it
  modport mul_side (
    input  a,
    input  b,
    input  val,
    output rdy
  );

endinterface

// ==== logic/imul_req_fifo.sv ====
//--------------------------------------
// imul request FIFO holding operand pairs
// in a circular buffer with val/rdy on
// both sides
//--------------------------------------

`include "imul_cfg.svh"

module imul_req_fifo (
  input  logic               clk,
  input  logic               reset,
  input  imul_pkg::operand_t in_a,
  input  imul_pkg::operand_t in_b,
  input  logic               in_val,
  output logic               in_rdy,
  imul_req_if.fifo_side      deq
);
  import imul_pkg::*;

  localparam int unsigned DEPTH = `IMUL_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // storage with one slot per queued request
  operand_t mem_a [DEPTH];
  operand_t mem_b [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic push;
  logic pop;

  //--------------------------------------
  // handshakes
  //--------------------------------------

  // accept while a slot is free
  assign in_rdy = (count != CNT_W'(DEPTH));
  assign push   = in_val && in_rdy;

  // head entry is valid while anything is queued
  assign deq.val = (count != '0);
  assign pop     = deq.val && deq.rdy;

  // head of queue straight from storage
  assign deq.a = mem_a[rd_ptr];
  assign deq.b = mem_b[rd_ptr];

  //--------------------------------------
  // pointers and occupancy
  //--------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // wrap at depth rather than at pointer width
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // payload write into the tail slot
  always_ff @(posedge clk) begin
    if (push) begin
      mem_a[wr_ptr] <= in_a;
      mem_b[wr_ptr] <= in_b;
    end
  end

  //--------------------------------------
  // checks
  //--------------------------------------

  // occupancy bounded by depth
  a_no_overflow : assert property (
    @(posedge clk) disable iff (reset)
    count <= CNT_W'(DEPTH)
  ) else $error("request FIFO occupancy above depth");

  // empty queue never wraps the count below zero
  a_no_underflow : assert property (
    @(posedge clk) disable iff (reset)
    (count == '0) |=> (count <= CNT_W'(1))
  ) else $error("request FIFO occupancy went below zero");

endmodule

// ==== logic/imul_ctrl.sv ====
//--------------------------------------
// imul controller with the IDLE/CALC/DONE
// FSM and the step counter of the multiply
//--------------------------------------

`include "imul_cfg.svh"

module imul_ctrl (
  input  logic         clk,
  input  logic         reset,
  imul_req_if.mul_side req,
  output logic         load,
  output logic         step,
  output logic         hold,
  output logic         resp_val,
  input  logic         resp_rdy
);
  import imul_pkg::*;

  localparam int unsigned STEPS = `IMUL_STEPS;
  localparam int unsigned CNT_W = $clog2(STEPS + 1);

  ctrl_state_t      state;
  logic [CNT_W-1:0] count;

  logic req_go;
  logic resp_go;
  logic last_step;

  //--------------------------------------
  // decoded outputs
  //--------------------------------------

  // one request at a time and only from IDLE
  assign req.rdy = (state == IDLE);
  assign req_go  = req.val && req.rdy;

  // operands captured on the accepting edge
  assign load = req_go;

  // one shift-and-add for every CALC cycle
  assign step = (state == CALC);

  // product sits in the datapath through DONE
  assign hold     = (state == DONE);
  assign resp_val = (state == DONE);
  assign resp_go  = resp_val && resp_rdy;

  assign last_step = (count == CNT_W'(STEPS - 1));

  //--------------------------------------
  // state and counter
  //--------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_go) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // product ready after the last step
          if (last_step) begin
            state <= DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          // wait out back-pressure
          if (resp_go) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  //--------------------------------------
  // checks
  //--------------------------------------

  // terminal count is never passed
  a_count_range : assert property (
    @(posedge clk) disable iff (reset)
    int'(count) < STEPS
  ) else $error("step counter past terminal count");

  // every load starts a fresh step run from count zero
  a_load_starts_run : assert property (
    @(posedge clk) disable iff (reset)
    load |=> (step && count == '0)
  ) else $error("load did not start a fresh step run");

endmodule

// ==== logic/imul_dpath.sv ====
//--------------------------------------
// imul datapath that strips operand signs,
// accumulates by shift and add and restores
// the sign of the product
//--------------------------------------

`include "imul_cfg.svh"

module imul_dpath (
  input  logic               clk,
  input  logic               reset,
  imul_req_if.mul_side       req,
  input  logic               load,
  input  logic               step,
  input  logic               hold,
  output imul_pkg::product_t result
);
  import imul_pkg::*;

  localparam int unsigned W = `IMUL_WIDTH;

  // multiplicand widened so it can shift left 32 times
  logic [2*W-1:0] a_sh;
  // multiplier consumed from the low bit
  logic [W-1:0]   b_sh;
  // running unsigned product
  logic [2*W-1:0] acc;
  // product sign as xor of operand signs
  logic           neg;

  logic [W-1:0] mag_a;
  logic [W-1:0] mag_b;
  logic [2*W-1:0] acc_next;

  //--------------------------------------
  // operand magnitudes
  //--------------------------------------

  // two's complement negate when negative
  // most negative value maps to 2^(W-1) which still fits unsigned
  assign mag_a = req.a[W-1] ? W'(-req.a) : W'(req.a);
  assign mag_b = req.b[W-1] ? W'(-req.b) : W'(req.b);

  //--------------------------------------
  // shift-and-add
  //--------------------------------------

  // partial product only when the current multiplier bit is set
  assign acc_next = b_sh[0] ? (acc + a_sh) : acc;

  // accumulator and product sign
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
      neg <= 1'b0;
    end else if (load) begin
      acc <= '0;
      neg <= req.a[W-1] ^ req.b[W-1];
    end else if (step) begin
      acc <= acc_next;
    end
  end

  // operand shifters
  always_ff @(posedge clk) begin
    if (load) begin
      a_sh <= {{W{1'b0}}, mag_a};
      b_sh <= mag_b;
    end else if (step) begin
      a_sh <= a_sh << 1;
      b_sh <= b_sh >> 1;
    end
  end

  //--------------------------------------
  // result
  //--------------------------------------

  // restore sign on the way out
  assign result = neg ? product_t'(-acc) : product_t'(acc);

  // response payload stays put while waiting for resp_rdy
  a_hold_stable : assert property (
    @(posedge clk) disable iff (reset)
    (hold && $past(hold)) |-> $stable(result)
  ) else $error("product changed while held");

endmodule

// ==== logic/imul_top.sv ====
//--------------------------------------
// imul top: request FIFO feeding the
// iterative signed 32x32 multiplier
//--------------------------------------

module imul_top (
  input  logic               clk,
  input  logic               reset,
  // request port
  input  imul_pkg::operand_t req_a,
  input  imul_pkg::operand_t req_b,
  input  logic               req_val,
  output logic               req_rdy,
  // response port
  output imul_pkg::product_t resp_result,
  output logic               resp_val,
  input  logic               resp_rdy
);

  // queue head to multiplier
  imul_req_if req_q ();

  // control to datapath
  logic load;
  logic step;
  logic hold;

  // request buffer
  imul_req_fifo fifo_inst (
    .clk    (clk),
    .reset  (reset),
    .in_a   (req_a),
    .in_b   (req_b),
    .in_val (req_val),
    .in_rdy (req_rdy),
    .deq    (req_q.fifo_side)
  );

  // sequencing and response handshake
  imul_ctrl ctrl_inst (
    .clk      (clk),
    .reset    (reset),
    .req      (req_q.mul_side),
    .load     (load),
    .step     (step),
    .hold     (hold),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // operands, accumulator, sign fixup
  imul_dpath dpath_inst (
    .clk    (clk),
    .reset  (reset),
    .req    (req_q.mul_side),
    .load   (load),
    .step   (step),
    .hold   (hold),
    .result (resp_result)
  );

endmodule

// ==== test/imul_tb.sv ====
//--------------------------------------
// imul testbench driving directed and
// random signed multiplies through the queue
//--------------------------------------

`include "imul_cfg.svh"

module imul_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import imul_pkg::*;

  localparam int DEPTH   = `IMUL_FIFO_DEPTH;
  localparam int TIMEOUT = 400;
  localparam int NUM_RANDOM = 40;
  localparam logic [31:0] LFSR_SEED = 32'd89709;

  localparam operand_t MAX_VAL = 32'sh7fff_ffff;
  localparam operand_t MIN_VAL = 32'sh8000_0000;

  logic     clk;
  logic     reset;
  operand_t req_a;
  operand_t req_b;
  logic     req_val;
  logic     req_rdy;
  product_t resp_result;
  logic     resp_val;
  logic     resp_rdy;

  logic [31:0] lfsr_state;

  imul_top imul_top_inst (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //--------------------------------------
  // helpers
  //--------------------------------------

  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // one lfsr step per operand bit
  task automatic rand_word(output operand_t w);
    w = '0;
    for (int i = 0; i < `IMUL_WIDTH; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w[i] = lfsr_state[0];
    end
  endtask

  // true signed product at full width
  function automatic product_t expected_product(input operand_t a, input operand_t b);
    return product_t'(a) * product_t'(b);
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    $display("TESTS FAILED");
    $fatal(1, "wait timed out");
  endtask

  // called on a falling edge and returns on the falling edge after the transfer
  task automatic send_req(input operand_t a, input operand_t b);
    int cycles;
    cycles = 0;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    while (!req_rdy) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) timeout_fail("request port never became ready");
    end
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic wait_resp_val();
    int cycles;
    cycles = 0;
    while (!resp_val) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) timeout_fail("no response from the multiplier");
    end
  endtask

  // resp_rdy must already be high
  task automatic take_resp(input product_t expected, input string what);
    wait_resp_val();
    check_value(resp_result, expected, what);
    @(negedge clk);
  endtask

  //--------------------------------------
  // tests
  //--------------------------------------

  task automatic test_reset_state();
    check_value(64'(resp_val), 64'd0, "resp_val after reset");
    check_value(64'(req_rdy), 64'd1, "req_rdy after reset");
  endtask

  task automatic run_pair(input operand_t a, input operand_t b);
    send_req(a, b);
    take_resp(expected_product(a, b), "directed product");
  endtask

  task automatic test_directed();
    resp_rdy = 1'b1;
    run_pair(32'sd0, 32'sd0);
    run_pair(32'sd0, -32'sd7);
    run_pair(32'sd1, 32'sd1);
    run_pair(32'sd1, -32'sd1);
    run_pair(-32'sd1, -32'sd1);
    // extremes in every sign combination
    run_pair(MAX_VAL, MAX_VAL);
    run_pair(MAX_VAL, MIN_VAL);
    run_pair(MIN_VAL, MAX_VAL);
    run_pair(MIN_VAL, MIN_VAL);
    run_pair(MIN_VAL, -32'sd1);
    run_pair(MAX_VAL, -32'sd1);
    run_pair(MIN_VAL, 32'sd1);
    // mixed signs
    run_pair(32'sd12345, -32'sd678);
    run_pair(-32'sd99999, 32'sd31337);
    run_pair(-32'sd65536, -32'sd65536);
  endtask

  task automatic test_random_stream();
    operand_t a_arr [NUM_RANDOM];
    operand_t b_arr [NUM_RANDOM];
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rand_word(a_arr[i]);
      rand_word(b_arr[i]);
    end
    resp_rdy = 1'b1;
    fork
      begin
        for (int i = 0; i < NUM_RANDOM; i++) begin
          send_req(a_arr[i], b_arr[i]);
        end
      end
      begin
        for (int j = 0; j < NUM_RANDOM; j++) begin
          take_resp(expected_product(a_arr[j], b_arr[j]), "random product");
        end
      end
    join
  endtask

  task automatic test_backpressure();
    product_t exp_q[$];
    product_t expected;
    operand_t a;
    operand_t b;
    int accepted;
    resp_rdy = 1'b0;
    accepted = 0;
    // fill until the queue pushes back
    while (req_rdy) begin
      rand_word(a);
      rand_word(b);
      req_a   = a;
      req_b   = b;
      req_val = 1'b1;
      @(negedge clk);
      exp_q.push_back(expected_product(a, b));
      accepted++;
      if (accepted > 2 * DEPTH + 4) timeout_fail("request port never filled");
    end
    req_val = 1'b0;
    check_value(64'(accepted), 64'(DEPTH + 1), "requests accepted under back-pressure");
    // queue stays full once the first product is held
    wait_resp_val();
    check_value(64'(req_rdy), 64'd0, "req_rdy while full");
    resp_rdy = 1'b1;
    while (exp_q.size() > 0) begin
      expected = exp_q.pop_front();
      take_resp(expected, "drained product");
    end
    check_value(64'(req_rdy), 64'd1, "req_rdy after drain");
  endtask

  task automatic test_hold_stable();
    operand_t a;
    operand_t b;
    product_t held;
    a = -32'sd123456789;
    b = 32'sd987654;
    resp_rdy = 1'b0;
    send_req(a, b);
    wait_resp_val();
    held = resp_result;
    check_value(held, expected_product(a, b), "held product");
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      check_value(64'(resp_val), 64'd1, "resp_val during hold");
      check_value(resp_result, held, "resp_result during hold");
    end
    // transfers on the first edge with resp_rdy high
    resp_rdy = 1'b1;
    @(negedge clk);
    check_value(64'(resp_val), 64'd0, "resp_val after accept");
  endtask

  //--------------------------------------
  // main sequence
  //--------------------------------------

  initial begin
    lfsr_state = LFSR_SEED;
    reset    = 1'b1;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_reset_state();
    test_directed();
    test_random_stream();
    test_backpressure();
    test_hold_stable();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/imul_pkg.sv
logic/imul_req_if.sv
logic/imul_req_fifo.sv
logic/imul_ctrl.sv
logic/imul_dpath.sv
logic/imul_top.sv
test/imul_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the imul testbench with Verilator.
# Pass or fail is decided from the simulation log.

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module imul_tb \
  -Mdir "$OBJ_DIR" \
  -o imul_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"$OBJ_DIR"/imul_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

exit 0
